// ==== verilog/uart_link_pkg.sv ====
//////////////////////////////////////////////////
// UART link types
// Byte, bit-timing and bit-index widths shared by
// the serial receiver and transmitter
//////////////////////////////////////////////////

package uart_link_pkg;

  // One payload byte on the line
  typedef logic [7:0] uart_byte_t;

  // Clocks elapsed within one bit period
  typedef logic [15:0] baud_cnt_t;

  // Position within a frame, start bit through stop bit
  typedef logic [3:0] bit_idx_t;

endpackage

// ==== verilog/dbg_proto_pkg.sv ====
//////////////////////////////////////////////////
// Debug protocol definitions
// Command and response codes, field sizes, the
// address and length types, and engine states
//////////////////////////////////////////////////

package dbg_proto_pkg;

  import uart_link_pkg::*;

  // Request and response bytes
  localparam uart_byte_t CmdRead  = 8'h11;
  localparam uart_byte_t CmdWrite = 8'h12;
  localparam uart_byte_t CmdExec  = 8'h13;
  localparam uart_byte_t RespAck  = 8'h06;
  localparam uart_byte_t RespEot  = 8'h04;

  // Address, length and entry fields, sent LSB first
  localparam int unsigned FieldBytes = 8;

  typedef logic [63:0] dbg_addr_t;
  typedef logic [63:0] dbg_len_t;

  typedef enum logic [2:0] {
    StIdle,
    StAddr,
    StLen,
    StAck,
    StRdFetch,
    StRdSend,
    StWrData,
    StEot
  } dbg_state_e;

endpackage

// ==== verilog/uart_rx.sv ====
//////////////////////////////////////////////////
// UART receiver
// 8N1 frames sampled at bit centres, one strobe
// per byte with a good stop bit
//////////////////////////////////////////////////

module uart_rx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      rx_i,
  output logic                      rx_valid_o,
  output uart_link_pkg::uart_byte_t rx_byte_o
);

  import uart_link_pkg::*;

  localparam baud_cnt_t HalfBit = baud_cnt_t'(ClksPerBit / 2 - 1);
  localparam baud_cnt_t FullBit = baud_cnt_t'(ClksPerBit - 1);
  localparam bit_idx_t  LastBit = bit_idx_t'(7);

  typedef enum logic [1:0] {
    RxIdle,
    RxStart,
    RxData,
    RxStop
  } rx_state_e;

  rx_state_e  state_q;
  logic [1:0] sync_q;
  logic       rx_s;
  baud_cnt_t  cnt_q;
  bit_idx_t   bit_q;
  uart_byte_t shift_q;
  logic       bit_tick;

  // Line idles high, so the synchronizer resets to one
  assign rx_s     = sync_q[1];
  assign bit_tick = (cnt_q == FullBit);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q     <= 2'b11;
      state_q    <= RxIdle;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      unique case (state_q)
        RxIdle: begin
          cnt_q <= '0;
          if (!rx_s) state_q <= RxStart;
        end
        RxStart: begin
          if (cnt_q == HalfBit) begin
            cnt_q <= '0;
            bit_q <= '0;
            // Glitch, not a start bit
            state_q <= rx_s ? RxIdle : RxData;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (bit_tick) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == LastBit) state_q <= RxStop;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RxStop: begin
          if (bit_tick) begin
            // Framing error drops the byte
            rx_valid_o <= rx_s;
            state_q    <= RxIdle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RxData && bit_tick) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

  a_rx_valid_pulse : assert property (
    @(posedge clk) disable iff (!rst_n_i) rx_valid_o |=> !rx_valid_o
  );

endmodule

// ==== verilog/uart_tx.sv ====
//////////////////////////////////////////////////
// UART transmitter
// Sends one 8N1 frame per start strobe
//////////////////////////////////////////////////

module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      tx_start_i,
  input  uart_link_pkg::uart_byte_t tx_byte_i,
  output logic                      tx_o,
  output logic                      tx_busy_o
);

  import uart_link_pkg::*;

  localparam baud_cnt_t FullBit  = baud_cnt_t'(ClksPerBit - 1);
  localparam bit_idx_t  LastData = bit_idx_t'(8);
  localparam bit_idx_t  StopIdx  = bit_idx_t'(9);

  baud_cnt_t  cnt_q;
  bit_idx_t   bit_q;
  uart_byte_t data_q;
  logic       load;
  logic       bit_end;

  assign load    = tx_start_i && !tx_busy_o;
  assign bit_end = tx_busy_o && (cnt_q == FullBit);

  // bit_q counts the bit on the line: 0 start, 1..8 data, 9 stop
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
      cnt_q     <= '0;
      bit_q     <= '0;
    end else if (load) begin
      tx_o      <= 1'b0;
      tx_busy_o <= 1'b1;
      cnt_q     <= '0;
      bit_q     <= '0;
    end else if (bit_end) begin
      cnt_q <= '0;
      bit_q <= bit_q + 1'b1;
      if (bit_q == StopIdx) begin
        tx_busy_o <= 1'b0;
        tx_o      <= 1'b1;
      end else if (bit_q == LastData) begin
        tx_o <= 1'b1;
      end else begin
        tx_o <= data_q[0];
      end
    end else if (tx_busy_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= tx_byte_i;
    end else if (bit_end && bit_q < LastData) begin
      data_q <= {1'b0, data_q[7:1]};
    end
  end

  // Engine must wait for the previous frame
  a_no_start_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n_i) tx_start_i |-> !tx_busy_o
  );

endmodule

// ==== verilog/dbg_cmd_engine.sv ====
//////////////////////////////////////////////////
// Debug command engine
// Decodes read, write and exec requests and the
// ACK challenge, moves data between the serial
// link and local memory and raises the exec strobe
//////////////////////////////////////////////////

module dbg_cmd_engine #(
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      rx_valid_i,
  input  uart_link_pkg::uart_byte_t rx_byte_i,
  output logic                      tx_start_o,
  output uart_link_pkg::uart_byte_t tx_byte_o,
  input  logic                      tx_busy_i,
  output logic                      mem_we_o,
  output logic [MemAddrWidth-1:0]   mem_addr_o,
  output uart_link_pkg::uart_byte_t mem_wdata_o,
  input  uart_link_pkg::uart_byte_t mem_rdata_i,
  output logic                      exec_valid_o,
  output dbg_proto_pkg::dbg_addr_t  exec_addr_o
);

  import uart_link_pkg::*;
  import dbg_proto_pkg::*;

  localparam int unsigned FldCntWidth = $clog2(FieldBytes);
  localparam int unsigned AddrBits    = $bits(dbg_addr_t);
  localparam int unsigned LenBits     = $bits(dbg_len_t);

  dbg_state_e             state_q;
  uart_byte_t             cmd_q;
  dbg_addr_t              addr_q;
  dbg_len_t               len_q;
  logic [FldCntWidth-1:0] fld_cnt_q;

  logic tx_ready;
  logic fld_last;
  logic addr_byte;
  logic len_byte;
  logic exec_take;
  logic rd_send;
  logic step;

  // tx_busy lags tx_start by a cycle, so a pending start also blocks
  assign tx_ready  = !tx_busy_i && !tx_start_o;
  assign fld_last  = (fld_cnt_q == FldCntWidth'(FieldBytes - 1));
  assign addr_byte = rx_valid_i && (state_q == StAddr);
  assign len_byte  = rx_valid_i && (state_q == StLen);
  assign exec_take = addr_byte && fld_last && (cmd_q == CmdExec);
  assign rd_send   = (state_q == StRdSend) && tx_ready;
  assign step      = rd_send || mem_we_o;

  // Upper address bits are dropped, accesses wrap
  assign mem_addr_o  = addr_q[MemAddrWidth-1:0];
  assign mem_we_o    = (state_q == StWrData) && rx_valid_i;
  assign mem_wdata_o = rx_byte_i;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q      <= StIdle;
      cmd_q        <= '0;
      fld_cnt_q    <= '0;
      tx_start_o   <= 1'b0;
      tx_byte_o    <= '0;
      exec_valid_o <= 1'b0;
    end else begin
      tx_start_o   <= 1'b0;
      exec_valid_o <= exec_take;
      unique case (state_q)
        StIdle: begin
          fld_cnt_q <= '0;
          if (rx_valid_i) begin
            cmd_q <= rx_byte_i;
            if (rx_byte_i == CmdRead || rx_byte_i == CmdWrite || rx_byte_i == CmdExec) begin
              state_q <= StAddr;
            end else if (rx_byte_i == RespAck) begin
              state_q <= StAck;
            end
          end
        end
        StAddr: begin
          if (rx_valid_i) begin
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (fld_last) state_q <= (cmd_q == CmdExec) ? StAck : StLen;
          end
        end
        StLen: begin
          if (rx_valid_i) begin
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (fld_last) state_q <= StAck;
          end
        end
        StAck: begin
          if (tx_ready) begin
            tx_start_o <= 1'b1;
            tx_byte_o  <= RespAck;
            if (cmd_q == CmdRead) begin
              state_q <= (len_q == '0) ? StEot : StRdFetch;
            end else if (cmd_q == CmdWrite) begin
              state_q <= (len_q == '0) ? StEot : StWrData;
            end else begin
              // Exec and challenge end here
              state_q <= StIdle;
            end
          end
        end
        // Registered read, one cycle for the data
        StRdFetch: state_q <= StRdSend;
        StRdSend: begin
          if (tx_ready) begin
            tx_start_o <= 1'b1;
            tx_byte_o  <= mem_rdata_i;
            state_q    <= (len_q == dbg_len_t'(1)) ? StEot : StRdFetch;
          end
        end
        StWrData: begin
          if (rx_valid_i && len_q == dbg_len_t'(1)) state_q <= StEot;
        end
        StEot: begin
          if (tx_ready) begin
            tx_start_o <= 1'b1;
            tx_byte_o  <= RespEot;
            state_q    <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Address, length and entry datapath
  //////////////////////////////////////////////////

  // Fields arrive little endian, shift in from the top
  always_ff @(posedge clk) begin
    if (addr_byte) begin
      addr_q <= {rx_byte_i, addr_q[AddrBits-1:8]};
    end else if (step) begin
      addr_q <= addr_q + 1'b1;
    end
    if (len_byte) begin
      len_q <= {rx_byte_i, len_q[LenBits-1:8]};
    end else if (step) begin
      len_q <= len_q - 1'b1;
    end
    if (exec_take) begin
      exec_addr_o <= {rx_byte_i, addr_q[AddrBits-1:8]};
    end
  end

  a_exec_pulse : assert property (
    @(posedge clk) disable iff (!rst_n_i) exec_valid_o |=> !exec_valid_o
  );

  // A memory write only while write data is still owed
  a_we_with_len : assert property (
    @(posedge clk) disable iff (!rst_n_i) mem_we_o |-> (len_q != '0)
  );

endmodule

// ==== verilog/dbg_byte_mem.sv ====
//////////////////////////////////////////////////
// Byte memory
// Single port, write on the edge, registered read
//////////////////////////////////////////////////

module dbg_byte_mem #(
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                      clk,
  input  logic                      we_i,
  input  logic [MemAddrWidth-1:0]   addr_i,
  input  uart_link_pkg::uart_byte_t wdata_i,
  output uart_link_pkg::uart_byte_t rdata_o
);

  import uart_link_pkg::*;

  localparam int unsigned Depth = 2 ** MemAddrWidth;

  uart_byte_t mem_q [Depth];

  // Read returns the old byte on a same-cycle write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

// ==== verilog/uart_dbg_top.sv ====
//////////////////////////////////////////////////
// UART debug target
// Serial receiver and transmitter around the
// command engine and its local byte memory
//////////////////////////////////////////////////

module uart_dbg_top #(
  parameter int unsigned ClksPerBit   = 16,
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     uart_rx_i,
  output logic                     uart_tx_o,
  output logic                     exec_valid_o,
  output dbg_proto_pkg::dbg_addr_t exec_addr_o
);

  import uart_link_pkg::*;

  logic                    rx_valid;
  uart_byte_t              rx_byte;
  logic                    tx_start;
  uart_byte_t              tx_byte;
  logic                    tx_busy;
  logic                    mem_we;
  logic [MemAddrWidth-1:0] mem_addr;
  uart_byte_t              mem_wdata;
  uart_byte_t              mem_rdata;

  //////////////////////////////////////////////////
  // Serial link
  //////////////////////////////////////////////////

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_o       ( uart_tx_o ),
    .tx_busy_o  ( tx_busy   )
  );

  //////////////////////////////////////////////////
  // Engine and memory
  //////////////////////////////////////////////////

  dbg_cmd_engine #(
    .MemAddrWidth ( MemAddrWidth )
  ) i_dbg_cmd_engine (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_valid_i   ( rx_valid     ),
    .rx_byte_i    ( rx_byte      ),
    .tx_start_o   ( tx_start     ),
    .tx_byte_o    ( tx_byte      ),
    .tx_busy_i    ( tx_busy      ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  dbg_byte_mem #(
    .MemAddrWidth ( MemAddrWidth )
  ) i_dbg_byte_mem (
    .clk     ( clk       ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

// ==== bench/tb_uart_dbg_tasks.svh ====
//////////////////////////////////////////////////
// Testbench tasks
// Serial frame driver, reply wait, value check
// and the directed debug protocol tests
//////////////////////////////////////////////////

`ifndef TB_UART_DBG_TASKS_SVH
`define TB_UART_DBG_TASKS_SVH

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
  check_count++;
  if (actual !== expected) begin
    $display("Fail at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    error_count++;
  end
endtask

// Memory wraps on the low address bits
function automatic int unsigned ref_index(input dbg_addr_t addr);
  return int'(addr[MemAddrWidth-1:0]);
endfunction

// One 8N1 frame, LSB first
task automatic send_byte(input uart_byte_t data);
  logic [9:0] frame;
  frame = {1'b1, data, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(posedge clk);
    uart_rx_i <= frame[i];
    repeat (ClksPerBit - 1) @(posedge clk);
  end
endtask

task automatic send_field(input logic [63:0] value);
  for (int i = 0; i < FieldBytes; i++) begin
    send_byte(value[8*i +: 8]);
  end
endtask

task automatic recv_byte(output uart_byte_t data);
  int unsigned waited;
  waited = 0;
  while (reply_q.size() == 0 && waited < RxTimeout) begin
    @(negedge clk);
    waited++;
  end
  if (reply_q.size() == 0) begin
    $display("Error at %0t: no reply byte from DUT", $time);
    error_count++;
    data = 'x;
  end else begin
    data = reply_q.pop_front();
  end
endtask

task automatic expect_byte(input uart_byte_t expected, input string what);
  uart_byte_t got;
  recv_byte(got);
  check_value(got, expected, what);
endtask

// Fixed quiet period on the reply line
task automatic expect_silence(input int unsigned bit_times);
  int unsigned pending;
  repeat (bit_times * ClksPerBit) @(negedge clk);
  pending = reply_q.size() + (mon_busy ? 1 : 0);
  check_value(pending, 0, "unexpected reply byte");
endtask

task automatic write_block(input dbg_addr_t addr, input int unsigned count);
  uart_byte_t data;
  send_byte(CmdWrite);
  send_field(addr);
  send_field(dbg_len_t'(count));
  expect_byte(RespAck, "write ACK");
  for (int i = 0; i < count; i++) begin
    data = uart_byte_t'($random(seed));
    ref_mem[ref_index(addr + i)] = data;
    send_byte(data);
  end
  expect_byte(RespEot, "write EOT");
endtask

task automatic read_block(input dbg_addr_t addr, input int unsigned count);
  send_byte(CmdRead);
  send_field(addr);
  send_field(dbg_len_t'(count));
  expect_byte(RespAck, "read ACK");
  for (int i = 0; i < count; i++) begin
    expect_byte(ref_mem[ref_index(addr + i)], $sformatf("read data byte %0d", i));
  end
  expect_byte(RespEot, "read EOT");
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic ack_challenge();
  send_byte(RespAck);
  expect_byte(RespAck, "challenge echo");
  expect_silence(20);
endtask

task automatic write_then_read();
  write_block(64'h20, 16);
  read_block(64'h20, 16);
endtask

// Upper address bits dropped, lands on 0xFE..0x01
task automatic address_wrap();
  write_block(64'h1_0000_00FE, 4);
  read_block(64'hFE, 4);
  read_block(64'h00, 2);
endtask

task automatic exec_entry();
  dbg_addr_t   entry;
  int unsigned start_count;
  int unsigned waited;
  entry       = 64'h8000_0000_1234_5678;
  start_count = exec_count;
  send_byte(CmdExec);
  send_field(entry);
  waited = 0;
  while (exec_count == start_count && waited < RxTimeout) begin
    @(negedge clk);
    waited++;
  end
  if (exec_count == start_count) begin
    $display("Error at %0t: exec strobe never pulsed", $time);
    error_count++;
  end
  // ACK still in flight when the strobe is seen
  check_value(reply_q.size(), 0, "ACK done before exec strobe");
  check_value(exec_addr_o, entry, "exec address");
  expect_byte(RespAck, "exec ACK");
  check_value(exec_count - start_count, 1, "exec strobe count");
endtask

task automatic unknown_bytes_ignored();
  send_byte(8'h55);
  send_byte(8'h14);
  expect_silence(30);
  ack_challenge();
endtask

`endif

// ==== bench/tb_uart_dbg.sv ====
//////////////////////////////////////////////////
// UART debug target testbench
// Sends debug requests on the serial input, decodes
// the replies and checks data and the exec strobe
//////////////////////////////////////////////////

module tb_uart_dbg;

  import uart_link_pkg::*;
  import dbg_proto_pkg::*;

  localparam int unsigned ClksPerBit   = 16;
  localparam int unsigned MemAddrWidth = 8;
  localparam int unsigned MemDepth     = 2 ** MemAddrWidth;
  localparam int unsigned RxTimeout    = 40 * ClksPerBit;
  localparam int          HalfBit      = ClksPerBit / 2 - 1;
  localparam int          StopCentre   = HalfBit + 9 * ClksPerBit;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      uart_rx_i;
  logic      uart_tx_o;
  logic      exec_valid_o;
  dbg_addr_t exec_addr_o;

  int unsigned error_count;
  int unsigned check_count;
  integer      seed;

  // Host copy of the target memory
  uart_byte_t ref_mem [MemDepth];

  // Reply decoder
  uart_byte_t reply_q [$];
  logic       mon_busy;
  int         mon_cnt;
  uart_byte_t mon_shift;

  int unsigned exec_count;

  always #10 clk = ~clk;

  uart_dbg_top #(
    .ClksPerBit   ( ClksPerBit   ),
    .MemAddrWidth ( MemAddrWidth )
  ) uart_dbg_top_inst (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  // Every frame on uart_tx_o, sampled at bit centres
  always @(posedge clk) begin
    if (!rst_n_i) begin
      mon_busy <= 1'b0;
      mon_cnt  <= 0;
    end else if (!mon_busy) begin
      if (!uart_tx_o) begin
        mon_busy <= 1'b1;
        mon_cnt  <= 1;
      end
    end else begin
      mon_cnt <= mon_cnt + 1;
      if (mon_cnt == HalfBit) begin
        if (uart_tx_o) begin
          $display("Error at %0t: reply start bit did not stay low", $time);
          error_count++;
          mon_busy <= 1'b0;
        end
      end else if (mon_cnt == StopCentre) begin
        mon_busy <= 1'b0;
        if (uart_tx_o) begin
          reply_q.push_back(mon_shift);
        end else begin
          $display("Error at %0t: reply frame has a low stop bit", $time);
          error_count++;
        end
      end else if ((mon_cnt - HalfBit) % ClksPerBit == 0) begin
        mon_shift <= {uart_tx_o, mon_shift[7:1]};
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n_i) begin
      exec_count <= 0;
    end else if (exec_valid_o) begin
      exec_count <= exec_count + 1;
    end
  end

  `include "tb_uart_dbg_tasks.svh"

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed        = 21;
    error_count = 0;
    check_count = 0;
    rst_n_i     = 1'b0;
    uart_rx_i   = 1'b1;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge clk);

    ack_challenge();
    write_then_read();
    address_wrap();
    exec_entry();
    unknown_bytes_ignored();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+bench
verilog/uart_link_pkg.sv
verilog/dbg_proto_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_cmd_engine.sv
verilog/dbg_byte_mem.sv
verilog/uart_dbg_top.sv
bench/tb_uart_dbg.sv

// ==== Bender.yml ====
package:
  name: uart_dbg

sources:
  - verilog/uart_link_pkg.sv
  - verilog/dbg_proto_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/dbg_cmd_engine.sv
  - verilog/dbg_byte_mem.sv
  - verilog/uart_dbg_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_uart_dbg.sv
